// File: common/decomp_pkg.sv
package decomp_pkg;

  // Block geometry
  localparam int WORD_W    = 8;
  localparam int NUM_WORDS = 32;
  localparam int BLOCK_W   = WORD_W * NUM_WORDS;

  // Pattern code space
  localparam int NUM_PATTERNS = 8;
  localparam int CODE_W       = $clog2(NUM_PATTERNS);

  // Width of data_i with the code above the payload
  localparam int IN_W = CODE_W + BLOCK_W;

  // Cycles from data_i to data_o, one per stage
  localparam int PIPE_DEPTH = 4;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [CODE_W-1:0]  code_t;
  typedef logic [1:0]         scan_t;

  localparam scan_t SCAN_RAW    = 2'd0;
  localparam scan_t SCAN_COLUMN = 2'd1;  // Column order is the identity
  localparam scan_t SCAN_ROW    = 2'd2;  // Plane-major order
  localparam scan_t SCAN_SNAKE  = 2'd3;  // Row order with odd planes reversed

  typedef struct packed {
    scan_t scan;
    logic  gray_en;
    logic  delta_en;
  } pattern_ctrl_t;

  // One pipeline beat that carries en along with the data
  typedef struct packed {
    logic          en;
    pattern_ctrl_t ctrl;
    block_t        payload;
  } block_beat_t;

  function automatic pattern_ctrl_t decode_pattern(code_t code);
    pattern_ctrl_t ctrl;
    ctrl = '0;
    case (code)
      3'd1: begin
        ctrl.scan     = SCAN_COLUMN;
        ctrl.delta_en = 1'b1;
      end
      3'd2: begin
        ctrl.scan     = SCAN_ROW;
        ctrl.gray_en  = 1'b1;
        ctrl.delta_en = 1'b1;
      end
      3'd3: begin
        ctrl.scan     = SCAN_SNAKE;
        ctrl.gray_en  = 1'b1;
        ctrl.delta_en = 1'b1;
      end
      3'd4: begin
        ctrl.scan     = SCAN_ROW;
        ctrl.gray_en  = 1'b1;
      end
      3'd5: begin
        ctrl.scan     = SCAN_SNAKE;
      end
      default: begin
        ctrl.scan     = SCAN_RAW;  // Code 0 and the reserved codes 6 and 7
      end
    endcase
    return ctrl;
  endfunction

endpackage

// File: hdl/block_unpack.sv
`timescale 1ns/1ps

module block_unpack (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          en_i,
  input  logic [decomp_pkg::IN_W-1:0]   data_i,

  output decomp_pkg::block_beat_t       beat_o
);

  decomp_pkg::code_t         code;
  decomp_pkg::block_t        payload;
  decomp_pkg::pattern_ctrl_t ctrl;

  assign code    = data_i[decomp_pkg::IN_W-1:decomp_pkg::BLOCK_W];
  assign payload = data_i[decomp_pkg::BLOCK_W-1:0];
  assign ctrl    = decomp_pkg::decode_pattern(code);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      beat_o <= '0;
    end else begin
      beat_o.en      <= en_i;
      beat_o.ctrl    <= ctrl;  // Later stages only see the decoded controls
      beat_o.payload <= payload;
    end
  end

endmodule

// File: hdl/decompressor.sv
`timescale 1ns/1ps

module decompressor (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          en_i,
  input  logic [decomp_pkg::IN_W-1:0]   data_i,

  output decomp_pkg::block_t            data_o,
  output logic                          en_o
);

  decomp_pkg::block_beat_t unpack_beat;
  decomp_pkg::block_beat_t descan_beat;
  decomp_pkg::block_beat_t dedbx_beat;

  // Stage 1 splits the code from the payload and decodes it
  block_unpack u_block_unpack (
    .clk     (clk),
    .rst_i   (rst_i),
    .en_i    (en_i),
    .data_i  (data_i),
    .beat_o  (unpack_beat)
  );

  plane_descan u_plane_descan (
    .clk     (clk),
    .rst_i   (rst_i),
    .beat_i  (unpack_beat),
    .beat_o  (descan_beat)
  );

  plane_dedbx u_plane_dedbx (
    .clk     (clk),
    .rst_i   (rst_i),
    .beat_i  (descan_beat),
    .beat_o  (dedbx_beat)
  );

  // Last stage drives the top outputs straight from its registers
  delta_detransform u_delta_detransform (
    .clk     (clk),
    .rst_i   (rst_i),
    .beat_i  (dedbx_beat),
    .data_o  (data_o),
    .en_o    (en_o)
  );

endmodule

// File: hdl/delta_detransform.sv
`timescale 1ns/1ps

module delta_detransform (
  input  logic                      clk,
  input  logic                      rst_i,
  input  decomp_pkg::block_beat_t   beat_i,

  output decomp_pkg::block_t        data_o,
  output logic                      en_o
);

  decomp_pkg::word_t  diff_w  [decomp_pkg::NUM_WORDS];
  decomp_pkg::word_t  rec_w   [decomp_pkg::NUM_WORDS];
  decomp_pkg::block_t rebuilt;

  // Word w holds its difference to the parent word (w-1)/2
  always_comb begin
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      diff_w[w] = beat_i.payload[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W];
    end
  end

  // Ascending word order walks the heap one level at a time, so every
  // parent is already rebuilt when its children need it
  always_comb begin
    rec_w[0] = diff_w[0];  // Root is stored as is
    for (int w = 1; w < decomp_pkg::NUM_WORDS; w++) begin
      rec_w[w] = diff_w[w] + rec_w[(w-1)/2];  // Wraps mod 256
    end
  end

  always_comb begin
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      rebuilt[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W] = rec_w[w];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      data_o <= '0;
      en_o   <= 1'b0;
    end else begin
      en_o <= beat_i.en;
      if (beat_i.ctrl.delta_en) begin
        data_o <= rebuilt;
      end else begin
        data_o <= beat_i.payload;
      end
    end
  end

endmodule

// File: hdl/plane_dedbx.sv
`timescale 1ns/1ps

module plane_dedbx (
  input  logic                      clk,
  input  logic                      rst_i,
  input  decomp_pkg::block_beat_t   beat_i,

  output decomp_pkg::block_beat_t   beat_o
);

  decomp_pkg::block_t plain_pl;

  // Each plane was XORed with the plane above it, so undo it from the MSB down
  function automatic decomp_pkg::word_t gray_decode(decomp_pkg::word_t coded);
    decomp_pkg::word_t plain;
    plain[decomp_pkg::WORD_W-1] = coded[decomp_pkg::WORD_W-1];
    for (int b = decomp_pkg::WORD_W - 2; b >= 0; b--) begin
      plain[b] = plain[b+1] ^ coded[b];
    end
    return plain;
  endfunction

  always_comb begin
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      plain_pl[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W] =
        gray_decode(beat_i.payload[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      beat_o <= '0;
    end else begin
      beat_o.en   <= beat_i.en;
      beat_o.ctrl <= beat_i.ctrl;
      if (beat_i.ctrl.gray_en) begin
        beat_o.payload <= plain_pl;
      end else begin
        beat_o.payload <= beat_i.payload;
      end
    end
  end

endmodule

// File: hdl/plane_descan.sv
`timescale 1ns/1ps

module plane_descan (
  input  logic                      clk,
  input  logic                      rst_i,
  input  decomp_pkg::block_beat_t   beat_i,

  output decomp_pkg::block_beat_t   beat_o
);

  decomp_pkg::block_t row_pl;
  decomp_pkg::block_t snake_pl;
  decomp_pkg::block_t column_pl;
  decomp_pkg::block_t descanned;

  // Input bit k belongs to plane k div 32 of word k mod 32
  for (genvar k = 0; k < decomp_pkg::BLOCK_W; k++) begin : g_bit
    localparam int ROW_WORD   = k % decomp_pkg::NUM_WORDS;
    localparam int PLANE      = k / decomp_pkg::NUM_WORDS;
    localparam int SNAKE_WORD = (PLANE % 2 == 1) ? decomp_pkg::NUM_WORDS - 1 - ROW_WORD
                                                 : ROW_WORD;

    assign row_pl[decomp_pkg::WORD_W*ROW_WORD + PLANE]     = beat_i.payload[k];
    assign snake_pl[decomp_pkg::WORD_W*SNAKE_WORD + PLANE] = beat_i.payload[k];
  end

  assign column_pl = beat_i.payload;  // Already word-major

  always_comb begin
    case (beat_i.ctrl.scan)
      decomp_pkg::SCAN_ROW: begin
        descanned = row_pl;
      end
      decomp_pkg::SCAN_SNAKE: begin
        descanned = snake_pl;
      end
      default: begin
        descanned = column_pl;  // Raw and column order keep the bit order
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      beat_o <= '0;
    end else begin
      beat_o.en      <= beat_i.en;
      beat_o.ctrl    <= beat_i.ctrl;
      beat_o.payload <= descanned;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the decompressor testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module decompressor_tb \
  -f vlog.f \
  -o Vdecompressor_tb

# The simulator exits non-zero on a failure, the log decides the verdict
./obj_dir/Vdecompressor_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test completed successfully" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see $LOG"
  exit 1
fi

// File: tests/decompressor_props.sv
`timescale 1ns/1ps

module decompressor_props (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               en_i,
  input  logic               en_out_i,
  input  decomp_pkg::block_t data_out_i
);

  // Every stage register clears on reset, so the outputs read zero one edge later
  property p_reset_clears;
    @(posedge clk) rst_i |=> (en_out_i == 1'b0 && data_out_i == '0);
  endproperty

  property p_en_delay;
    @(posedge clk) disable iff (rst_i) en_out_i == $past(en_i, decomp_pkg::PIPE_DEPTH);
  endproperty

  property p_en_known;
    @(posedge clk) disable iff (rst_i) !$isunknown(en_out_i);
  endproperty

  a_reset_clears: assert property (p_reset_clears)
    else $error("outputs not cleared after reset");

  a_en_delay: assert property (p_en_delay)
    else $error("en_o does not follow en_i by the pipeline depth");

  a_en_known: assert property (p_en_known)
    else $error("en_o is unknown outside reset");

endmodule

bind decompressor decompressor_props u_props (
  .clk        (clk),
  .rst_i      (rst_i),
  .en_i       (en_i),
  .en_out_i   (en_o),
  .data_out_i (data_o)
);

// File: tests/decompressor_tb.sv
`timescale 1ns/1ps

module decompressor_tb;

  localparam int CLK_PERIOD        = 100;
  localparam int RST_CYCLES        = 8;
  localparam int IDLE_CYCLES       = 6;
  localparam int DIRECTED_PER_CODE = 4;
  localparam int N_RANDOM          = 300;
  localparam int DRAIN_CYCLES      = decomp_pkg::PIPE_DEPTH + 2;
  localparam int TOTAL_CYCLES      = RST_CYCLES + IDLE_CYCLES + DRAIN_CYCLES
                                     + decomp_pkg::NUM_PATTERNS * DIRECTED_PER_CODE + N_RANDOM;
  localparam int MARGIN_CYCLES     = 20;

  logic                        clk;
  logic                        rst_i;
  logic                        en_i;
  logic [decomp_pkg::IN_W-1:0] data_i;
  decomp_pkg::block_t          data_o;
  logic                        en_o;

  decomp_pkg::block_t exp_q[$];
  logic [31:0]        lfsr_state;
  bit                 first_seen;

  decompressor dut (
    .clk    (clk),
    .rst_i  (rst_i),
    .en_i   (en_i),
    .data_i (data_i),
    .data_o (data_o),
    .en_o   (en_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR with taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic [31:0] nxt;
    nxt = s >> 1;
    if (s[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  task automatic random_bits(input int n, output decomp_pkg::block_t bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i]    = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Word w gets w*step+1, so neighbours and parents differ
  function automatic decomp_pkg::block_t ramp_block(int step);
    decomp_pkg::block_t blk;
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      blk[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W] = decomp_pkg::word_t'(w * step + 1);
    end
    return blk;
  endfunction

  function automatic decomp_pkg::block_t expected_block(decomp_pkg::code_t code,
                                                        decomp_pkg::block_t payload);
    decomp_pkg::block_t scanned;
    decomp_pkg::block_t result;
    decomp_pkg::word_t  words [decomp_pkg::NUM_WORDS];
    logic               reorder;
    logic               snake;
    logic               do_gray;
    logic               do_delta;
    int                 plane;
    int                 word;
    reorder  = (code == 3'd2) || (code == 3'd3) || (code == 3'd4) || (code == 3'd5);
    snake    = (code == 3'd3) || (code == 3'd5);
    do_gray  = (code == 3'd2) || (code == 3'd3) || (code == 3'd4);
    do_delta = (code == 3'd1) || (code == 3'd2) || (code == 3'd3);
    scanned  = payload;  // Raw and column order keep the bits where they are
    if (reorder) begin
      for (int k = 0; k < decomp_pkg::BLOCK_W; k++) begin
        plane = k / decomp_pkg::NUM_WORDS;
        word  = k % decomp_pkg::NUM_WORDS;
        if (snake && (plane % 2 == 1)) begin
          word = decomp_pkg::NUM_WORDS - 1 - word;
        end
        scanned[decomp_pkg::WORD_W*word + plane] = payload[k];
      end
    end
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      words[w] = scanned[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W];
    end
    if (do_gray) begin
      for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
        for (int b = decomp_pkg::WORD_W - 2; b >= 0; b--) begin
          words[w][b] = words[w][b+1] ^ words[w][b];  // Bit above is already decoded
        end
      end
    end
    if (do_delta) begin
      for (int w = 1; w < decomp_pkg::NUM_WORDS; w++) begin
        words[w] = words[w] + words[(w-1)/2];
      end
    end
    for (int w = 0; w < decomp_pkg::NUM_WORDS; w++) begin
      result[w*decomp_pkg::WORD_W +: decomp_pkg::WORD_W] = words[w];
    end
    return result;
  endfunction

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_block(input decomp_pkg::block_t got, input decomp_pkg::block_t exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s mismatch", $time, what);
      $display("  got      %h", got);
      $display("  expected %h", exp);
      fail_run();
    end
  endtask

  task automatic check_en(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: en_o is %b, en_i %0d cycles earlier was %b",
               $time, got, decomp_pkg::PIPE_DEPTH, exp);
      fail_run();
    end
  endtask

  task automatic drive_beat(input logic en, input decomp_pkg::code_t code,
                            input decomp_pkg::block_t payload);
    @(posedge clk);
    en_i   <= en;
    data_i <= {code, payload};
    if (en) begin
      exp_q.push_back(expected_block(code, payload));
    end
  endtask

  initial begin : stimulus
    decomp_pkg::block_t bits;
    decomp_pkg::block_t payload;
    decomp_pkg::code_t  code;
    logic               en;
    lfsr_state = 32'd73863;
    rst_i      = 1'b1;
    en_i       = 1'b0;
    data_i     = '1;  // Garbage on the bus during reset must not reach the outputs
    repeat (RST_CYCLES) @(posedge clk);
    rst_i  <= 1'b0;
    data_i <= '0;
    repeat (IDLE_CYCLES) drive_beat(1'b0, '0, '0);  // Outputs must stay at zero here

    // Every code back to back with one ramp and three random payloads each
    for (int c = 0; c < decomp_pkg::NUM_PATTERNS; c++) begin
      drive_beat(1'b1, decomp_pkg::code_t'(c), ramp_block(c + 3));
      for (int i = 1; i < DIRECTED_PER_CODE; i++) begin
        random_bits(decomp_pkg::BLOCK_W, payload);
        drive_beat(1'b1, decomp_pkg::code_t'(c), payload);
      end
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      random_bits(1, bits);
      en = bits[0];
      random_bits(decomp_pkg::CODE_W, bits);
      code = bits[decomp_pkg::CODE_W-1:0];
      random_bits(decomp_pkg::BLOCK_W, payload);
      drive_beat(en, code, payload);
    end

    repeat (DRAIN_CYCLES) drive_beat(1'b0, '0, '0);
    @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("%0d expected blocks never came out of the DUT", exp_q.size());
      fail_run();
    end
  end

  // Sampling at the falling edge keeps clear of the drive edge
  initial begin : compare
    logic [decomp_pkg::PIPE_DEPTH-1:0] en_hist;
    en_hist    = '0;
    first_seen = 1'b0;
    forever begin
      @(negedge clk);
      check_en(en_o, en_hist[decomp_pkg::PIPE_DEPTH-1]);
      en_hist = {en_hist[decomp_pkg::PIPE_DEPTH-2:0], en_i};
      if (en_o) begin
        first_seen = 1'b1;
        if (exp_q.size() == 0) begin
          $display("The DUT sent out a block while none was expected");
          fail_run();
        end else begin
          check_block(data_o, exp_q.pop_front(), "data_o");
        end
      end else if (!first_seen) begin
        check_block(data_o, '0, "data_o before the first beat");
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run took longer than %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
    fail_run();
  end

endmodule

// File: vlog.f
common/decomp_pkg.sv
hdl/block_unpack.sv
hdl/plane_descan.sv
hdl/plane_dedbx.sv
hdl/delta_detransform.sv
hdl/decompressor.sv
tests/decompressor_props.sv
tests/decompressor_tb.sv
